//--- verilog.f
+incdir+hw
hw/rv32i_types.sv
hw/regfile.sv
hw/decode.sv
hw/alu.sv
hw/cmp.sv
hw/execute.sv
hw/writeback.sv
hw/ex_pipe_top.sv
sim/tb_ex_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build the execute slice with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_ex_pipe -f verilog.f -o tb_ex_pipe \
    && ./obj_dir/tb_ex_pipe > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_ex_pipe.sv
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module tb_ex_pipe;
    import rv32i_types::*;

    localparam int timeout_cycles = 20;

    // addi xori ori andi slli srli srai slti sltiu.
    localparam logic [2:0] imm_f3 [0:8] = '{3'b000, 3'b100, 3'b110, 3'b111, 3'b001,
                                            3'b101, 3'b101, 3'b010, 3'b011};
    // add sub sll slt sltu xor srl sra or and.
    localparam logic [2:0] reg_f3 [0:9] = '{3'b000, 3'b000, 3'b001, 3'b010, 3'b011,
                                            3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
    localparam logic       reg_alt [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                             1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    localparam logic [2:0] br_f3 [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic          clk;
    logic          rst_n;
    logic          issue_valid;
    rv32i_instr_u  issue_instr;
    rv32i_word     issue_pc;
    EX_MEM_stage_t ex_mem;
    logic          wb_we;
    rv32i_reg      wb_rd;
    rv32i_word     wb_data;

    integer    seed;
    string     test_name;
    rv32i_word pc_now;
    rv32i_word model_regs [0:`RV_NREGS-1]; // reference copy of the register file.

    ex_pipe_top u_dut
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .ex_mem      (ex_mem),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################################################
    // encoders and reference model
    // ########################################################################
    function automatic rv32i_word rand_word();
        return $random(seed);
    endfunction

    function automatic rv32i_word sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic rv32i_instr_u enc_r(input logic [6:0] f7, input rv32i_reg rs2,
                                           input rv32i_reg rs1, input logic [2:0] f3,
                                           input rv32i_reg rd, input logic [6:0] op);
        return rv32i_instr_u'({f7, rs2, rs1, f3, rd, op});
    endfunction

    function automatic rv32i_instr_u enc_i(input logic [11:0] imm, input rv32i_reg rs1,
                                           input logic [2:0] f3, input rv32i_reg rd,
                                           input logic [6:0] op);
        return rv32i_instr_u'({imm, rs1, f3, rd, op});
    endfunction

    function automatic rv32i_instr_u enc_s(input logic [11:0] imm, input rv32i_reg rs2,
                                           input rv32i_reg rs1, input logic [2:0] f3);
        return rv32i_instr_u'({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011});
    endfunction

    function automatic rv32i_instr_u enc_b(input logic [12:0] imm, input rv32i_reg rs2,
                                           input rv32i_reg rs1, input logic [2:0] f3);
        return rv32i_instr_u'({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                               7'b1100011});
    endfunction

    function automatic rv32i_instr_u enc_u(input logic [19:0] imm, input rv32i_reg rd,
                                           input logic [6:0] op);
        return rv32i_instr_u'({imm, rd, op});
    endfunction

    function automatic rv32i_instr_u enc_j(input logic [20:0] imm, input rv32i_reg rd);
        return rv32i_instr_u'({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111});
    endfunction

    // rv32i integer op by funct3 and instruction bit 30 (alt).
    function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv32i_word a, input rv32i_word b);
        rv32i_word res;
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'd0, $signed(a) < $signed(b)};
            3'b011:  res = {31'd0, a < b};
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default:
            begin
                if (alt)
                begin
                    res = rv32i_word'($signed(a) >>> b[4:0]);
                end
                else
                begin
                    res = a >> b[4:0];
                end
            end
        endcase
        return res;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv32i_word a,
                                        input rv32i_word b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ########################################################################
    // compare tasks
    // ########################################################################
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input rv32i_word exp, input rv32i_word act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_pcmux(input string what, input pcmux_sel_t exp,
                               input pcmux_sel_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s: expected %s, actual %s", test_name, what,
                     exp.name(), act.name());
            stop_run();
        end
    endtask

    task automatic check_reg(input string what, input rv32i_reg exp, input rv32i_reg act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s: expected x%0d, actual x%0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // checks the write port in the result cycle and updates the model.
    task automatic check_writeback(input rv32i_reg rd, input rv32i_word value);
        if (rd == '0)
        begin
            check_flag("wb_we for x0", 1'b0, wb_we);
        end
        else
        begin
            check_flag("wb_we", 1'b1, wb_we);
            check_reg("wb_rd", rd, wb_rd);
            check_word("wb_data", value, wb_data);
            model_regs[rd] = value;
        end
    endtask

    // ########################################################################
    // issue and wait
    // ########################################################################
    task automatic run_instr(input rv32i_instr_u instr);
        int waited;
        waited = 0;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_instr <= instr;
        issue_pc    <= pc_now;
        @(posedge clk);
        issue_valid <= 1'b0;
        @(negedge clk);
        while (!ex_mem.ctrl_wd.valid)
        begin
            if (waited == timeout_cycles)
            begin
                $display("timeout: no valid result on ex_mem within %0d cycles in %s",
                         timeout_cycles, test_name);
                stop_run();
            end
            else
            begin
                waited++;
                @(negedge clk);
            end
        end
        check_word("ex_mem pc", pc_now, ex_mem.ctrl_wd.pc);
        pc_now = pc_now + 32'd4;
    endtask

    // lui with the upper part rounded for the signed addi low half.
    task automatic load_reg(input rv32i_reg rd, input rv32i_word value);
        rv32i_word hi;
        hi = value + 32'h800;
        run_instr(enc_u(hi[31:12], rd, op_lui));
        check_writeback(rd, {hi[31:12], 12'h000});
        run_instr(enc_i(value[11:0], rd, 3'b000, rd, op_imm));
        check_writeback(rd, value);
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################
    task automatic reset_readback();
        test_name = "reset";
        @(negedge clk);
        check_flag("ex_mem valid", 1'b0, ex_mem.ctrl_wd.valid);
        check_flag("wb_we", 1'b0, wb_we);
        // starts at x1 so that x1 is read before it is written.
        for (int r = 0; r < `RV_NREGS; r++)
        begin
            run_instr(enc_r(7'h00, 5'd0, rv32i_reg'(r + 1), 3'b000, 5'd1, op_reg));
            check_writeback(5'd1, 32'h0);
        end
    endtask

    task automatic imm_alu();
        rv32i_word   a;
        rv32i_word   rnd;
        logic [11:0] imm;
        logic        alt;
        rv32i_reg    rd;
        test_name = "imm_alu";
        for (int k = 0; k < 9; k++)
        begin
            for (int n = 0; n < 3; n++)
            begin
                a   = rand_word();
                rnd = rand_word();
                alt = (k == 6);
                imm = rnd[11:0];
                if (imm_f3[k] == 3'b001 || imm_f3[k] == 3'b101)
                begin
                    imm = {1'b0, alt, 5'b00000, rnd[4:0]}; // shamt form.
                end
                rd = (n == 2) ? 5'd0 : 5'd6;
                load_reg(5'd5, a);
                run_instr(enc_i(imm, 5'd5, imm_f3[k], rd, op_imm));
                check_writeback(rd, alu_ref(imm_f3[k], alt, a, sext12(imm)));
            end
        end
    endtask

    task automatic reg_alu();
        rv32i_word expected;
        test_name = "reg_alu";
        for (int k = 0; k < 10; k++)
        begin
            for (int n = 0; n < 2; n++)
            begin
                load_reg(5'd5, rand_word());
                load_reg(5'd6, rand_word());
                expected = alu_ref(reg_f3[k], reg_alt[k], model_regs[5], model_regs[6]);
                run_instr(enc_r({1'b0, reg_alt[k], 5'b00000}, 5'd6, 5'd5, reg_f3[k],
                                5'd7, op_reg));
                check_writeback(5'd7, expected);
            end
        end
    endtask

    task automatic upper_imm();
        rv32i_word rnd;
        rv32i_word pc;
        test_name = "upper_imm";
        for (int n = 0; n < 4; n++)
        begin
            rnd = rand_word();
            run_instr(enc_u(rnd[31:12], 5'd8, op_lui));
            check_word("lui u_imm", {rnd[31:12], 12'h000}, ex_mem.u_imm);
            check_writeback(5'd8, {rnd[31:12], 12'h000});
            rnd = rand_word();
            pc  = pc_now;
            run_instr(enc_u(rnd[31:12], 5'd9, op_auipc));
            check_writeback(5'd9, pc + {rnd[31:12], 12'h000});
        end
    endtask

    task automatic control_flow();
        rv32i_word rnd;
        rv32i_word off;
        rv32i_word pc;
        rv32i_reg  rs1;
        rv32i_reg  rs2;
        logic      taken;
        test_name = "control";
        load_reg(5'd10, 32'hffff_fffb); // -5 signed but large unsigned.
        load_reg(5'd11, 32'd3);
        for (int k = 0; k < 6; k++)
        begin
            for (int p = 0; p < 3; p++)
            begin
                rs1   = (p == 1) ? 5'd11 : 5'd10;
                rs2   = (p == 0) ? 5'd11 : 5'd10;
                rnd   = rand_word();
                off   = {{19{rnd[12]}}, rnd[12:1], 1'b0};
                pc    = pc_now;
                taken = branch_ref(br_f3[k], model_regs[rs1], model_regs[rs2]);
                run_instr(enc_b(off[12:0], rs2, rs1, br_f3[k]));
                check_pcmux("branch pcmux_sel", taken ? pcmux_alu_out : pcmux_pc_plus4,
                            ex_mem.pcmux_sel);
                check_flag("branch cmp_out", taken, ex_mem.cmp_out);
                check_word("branch target", pc + off, ex_mem.alu_out);
                check_flag("branch wb_we", 1'b0, wb_we);
            end
        end
        for (int n = 0; n < 3; n++)
        begin
            rnd = rand_word();
            off = {{11{rnd[20]}}, rnd[20:1], 1'b0};
            pc  = pc_now;
            run_instr(enc_j(off[20:0], 5'd12));
            check_pcmux("jal pcmux_sel", pcmux_alu_out, ex_mem.pcmux_sel);
            check_word("jal target", pc + off, ex_mem.alu_out);
            check_writeback(5'd12, pc + 32'd4);
            rnd = rand_word();
            pc  = pc_now;
            run_instr(enc_i(rnd[11:0], 5'd10, 3'b000, 5'd13, op_jalr));
            check_pcmux("jalr pcmux_sel", pcmux_alu_mod2, ex_mem.pcmux_sel);
            check_word("jalr target", model_regs[10] + sext12(rnd[11:0]), ex_mem.alu_out);
            check_writeback(5'd13, pc + 32'd4);
        end
    endtask

    task automatic store_lanes();
        rv32i_word   rnd;
        rv32i_word   base;
        rv32i_word   addr;
        logic [11:0] imm;
        logic [1:0]  lane;
        test_name = "store";
        load_reg(5'd14, rand_word());
        base = model_regs[14];
        for (int s = 0; s < 3; s++) // sb, sh, sw.
        begin
            for (int l = 0; l < 4; l++)
            begin
                load_reg(5'd15, rand_word());
                rnd      = rand_word();
                lane     = l[1:0];
                imm      = rnd[11:0];
                imm[1:0] = lane - base[1:0]; // lands on the wanted byte lane.
                addr     = base + sext12(imm);
                run_instr(enc_s(imm, 5'd15, 5'd14, s[2:0]));
                check_word("mar", addr, ex_mem.mar);
                check_word("mem_data_out", model_regs[15] << (8 * lane), ex_mem.mem_data_out);
                check_flag("store wb_we", 1'b0, wb_we);
            end
        end
    endtask

    // ########################################################################
    // main sequence
    // ########################################################################
    initial
    begin
        seed        = 32'ha37e;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_pc    = '0;
        pc_now      = `RV_RESET_PC;
        test_name   = "init";
        for (int r = 0; r < `RV_NREGS; r++)
        begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        reset_readback();
        imm_alu();
        reg_alu();
        upper_imm();
        control_flow();
        store_lanes();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- hw/ex_pipe_top.sv
`timescale 1ns/100ps

module ex_pipe_top
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_valid,
    input  rv32i_types::rv32i_instr_u  issue_instr,
    input  rv32i_types::rv32i_word     issue_pc,
    output rv32i_types::EX_MEM_stage_t ex_mem,
    output logic                       wb_we,
    output rv32i_types::rv32i_reg      wb_rd,
    output rv32i_types::rv32i_word     wb_data
);
    import rv32i_types::*;

    rv32i_reg      rs1_addr;
    rv32i_reg      rs2_addr;
    rv32i_word     rs1_data;
    rv32i_word     rs2_data;
    ID_EX_stage_t  id_ex;
    EX_MEM_stage_t ex_result;

    regfile u_regfile
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (wb_we),
        .rd       (wb_rd),
        .wdata    (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode u_decode
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

    execute u_execute
    (
        .ex_in  (id_ex),
        .ex_out (ex_result)
    );

    writeback u_writeback
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_result (ex_result),
        .ex_mem    (ex_mem),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

//--- hw/writeback.sv
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module writeback
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv32i_types::EX_MEM_stage_t ex_result,
    output rv32i_types::EX_MEM_stage_t ex_mem,
    output logic                       wb_we,
    output rv32i_types::rv32i_reg      wb_rd,
    output rv32i_types::rv32i_word     wb_data
);
    import rv32i_types::*;

    // ########################################################################
    // EX/MEM register
    // ########################################################################
    always_ff @(posedge clk)
    begin
        ex_mem <= ex_result;
        if (!rst_n)
        begin
            ex_mem.ctrl_wd.valid        <= 1'b0;
            ex_mem.ctrl_wd.load_regfile <= 1'b0;
        end
    end

    assign wb_rd = ex_mem.rd;
    assign wb_we = ex_mem.ctrl_wd.valid && ex_mem.ctrl_wd.load_regfile
                   && (ex_mem.rd != '0); // x0 never written.

    always_comb
    begin
        case (ex_mem.ctrl_wd.wbmux_sel)
            wbmux_br_en:    wb_data = {{(`RV_XLEN-1){1'b0}}, ex_mem.cmp_out};
            wbmux_u_imm:    wb_data = ex_mem.u_imm;
            wbmux_pc_plus4: wb_data = ex_mem.ctrl_wd.pc + 32'd4; // link address.
            default:        wb_data = ex_mem.alu_out;
        endcase
    end

endmodule

//--- hw/execute.sv
`timescale 1ns/100ps

module execute
(
    input  rv32i_types::ID_EX_stage_t  ex_in,
    output rv32i_types::EX_MEM_stage_t ex_out
);
    import rv32i_types::*;

    ex_ctrl_t  ctrl;
    rv32i_word alumux1_out;
    rv32i_word alumux2_out;
    rv32i_word cmpmux_out;
    rv32i_word alu_out;
    rv32i_word marmux_out;
    logic      br_en;

    assign ctrl = ex_in.ctrl_wd.ex_ctrlwd;

    alu u_alu
    (
        .aluop (ctrl.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_out)
    );

    cmp u_cmp
    (
        .cmpop (ctrl.cmpop),
        .a     (ex_in.rs1_out),
        .b     (cmpmux_out),
        .br_en (br_en)
    );

    // ########################################################################
    // operand muxes
    // ########################################################################
    always_comb
    begin
        alumux1_out = (ctrl.alumux1_sel == alumux1_pc_out) ? ex_in.ctrl_wd.pc : ex_in.rs1_out;
        case (ctrl.alumux2_sel)
            alumux2_u_imm:   alumux2_out = ex_in.u_imm;
            alumux2_b_imm:   alumux2_out = ex_in.b_imm;
            alumux2_s_imm:   alumux2_out = ex_in.s_imm;
            alumux2_j_imm:   alumux2_out = ex_in.j_imm;
            alumux2_rs2_out: alumux2_out = ex_in.rs2_out;
            default:         alumux2_out = ex_in.i_imm;
        endcase
        cmpmux_out = (ctrl.cmpmux_sel == cmpmux_i_imm) ? ex_in.i_imm : ex_in.rs2_out;
        marmux_out = (ctrl.marmux_sel == marmux_alu_out) ? alu_out : ex_in.ctrl_wd.pc;
    end

    // results for the EX/MEM register.
    always_comb
    begin
        ex_out              = '0;
        ex_out.ctrl_wd      = ex_in.ctrl_wd;
        ex_out.alu_out      = alu_out;
        ex_out.cmp_out      = br_en;
        ex_out.mar          = marmux_out;
        ex_out.mem_data_out = ex_in.rs2_out << {marmux_out[1:0], 3'b000}; // byte lane.
        ex_out.u_imm        = ex_in.u_imm;
        ex_out.rd           = ex_in.rd;
        if (ex_in.ctrl_wd.opcode == op_jalr)
        begin
            ex_out.pcmux_sel = pcmux_alu_mod2;
        end
        else if (ex_in.ctrl_wd.opcode == op_jal || (ctrl.is_branch && br_en))
        begin
            ex_out.pcmux_sel = pcmux_alu_out;
        end
        else
        begin
            ex_out.pcmux_sel = pcmux_pc_plus4;
        end
    end

endmodule

//--- hw/cmp.sv
`timescale 1ns/100ps

module cmp
(
    input  rv32i_types::branch_funct3 cmpop,
    input  rv32i_types::rv32i_word    a,
    input  rv32i_types::rv32i_word    b,
    output logic                      br_en
);
    import rv32i_types::*;

    // also used for slt and sltu.
    always_comb
    begin
        case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = ($signed(a) < $signed(b));
            bge:     br_en = ($signed(a) >= $signed(b));
            bltu:    br_en = (a < b);
            bgeu:    br_en = (a >= b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu
(
    input  rv32i_types::alu_ops    aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // rv32i shift amount.

    always_comb
    begin
        case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << shamt;
            alu_sra: f = rv32i_word'($signed(a) >>> shamt); // keeps the sign.
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = '0;
        endcase
    end

endmodule

//--- hw/decode.sv
`timescale 1ns/100ps

module decode
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue_valid,
    input  rv32i_types::rv32i_instr_u   issue_instr,
    input  rv32i_types::rv32i_word      issue_pc,
    output rv32i_types::rv32i_reg       rs1_addr,
    output rv32i_types::rv32i_reg       rs2_addr,
    input  rv32i_types::rv32i_word      rs1_data,
    input  rv32i_types::rv32i_word      rs2_data,
    output rv32i_types::ID_EX_stage_t   id_ex
);
    import rv32i_types::*;

    ID_EX_stage_t id_next;
    ctrl_word_t   ctrl;
    logic         alt; // instruction bit 30.

    assign rs1_addr = issue_instr.r.rs1;
    assign rs2_addr = issue_instr.r.rs2;
    assign alt      = issue_instr.r.funct7[5];

    // ########################################################################
    // control word
    // ########################################################################
    always_comb
    begin
        ctrl                       = '0;
        ctrl.valid                 = issue_valid;
        ctrl.opcode                = rv32i_opcode'(issue_instr.r.opcode);
        ctrl.pc                    = issue_pc;
        ctrl.funct3                = issue_instr.r.funct3;
        ctrl.wbmux_sel             = wbmux_alu_out;
        ctrl.ex_ctrlwd.aluop       = alu_add;
        ctrl.ex_ctrlwd.cmpop       = branch_funct3'(issue_instr.r.funct3);
        ctrl.ex_ctrlwd.alumux1_sel = alumux1_rs1_out;
        ctrl.ex_ctrlwd.alumux2_sel = alumux2_i_imm;
        ctrl.ex_ctrlwd.cmpmux_sel  = cmpmux_rs2_out;
        ctrl.ex_ctrlwd.marmux_sel  = marmux_pc_out;
        case (issue_instr.r.opcode)
            op_lui:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.wbmux_sel    = wbmux_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile          = 1'b1;
                ctrl.ex_ctrlwd.alumux1_sel = alumux1_pc_out;
                ctrl.ex_ctrlwd.alumux2_sel = alumux2_u_imm;
            end
            op_jal:
            begin
                ctrl.load_regfile          = 1'b1;
                ctrl.wbmux_sel             = wbmux_pc_plus4;
                ctrl.ex_ctrlwd.alumux1_sel = alumux1_pc_out;
                ctrl.ex_ctrlwd.alumux2_sel = alumux2_j_imm;
            end
            op_jalr:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.wbmux_sel    = wbmux_pc_plus4;
            end
            op_br:
            begin
                ctrl.ex_ctrlwd.alumux1_sel = alumux1_pc_out; // target is pc + b_imm.
                ctrl.ex_ctrlwd.alumux2_sel = alumux2_b_imm;
                ctrl.ex_ctrlwd.is_branch   = 1'b1;
            end
            op_load, op_store:
            begin
                ctrl.ex_ctrlwd.marmux_sel = marmux_alu_out; // no write back here.
                if (issue_instr.r.opcode == op_store)
                begin
                    ctrl.ex_ctrlwd.alumux2_sel = alumux2_s_imm;
                end
            end
            op_imm, op_reg:
            begin
                ctrl.load_regfile    = 1'b1;
                ctrl.ex_ctrlwd.aluop = alu_ops'(issue_instr.r.funct3);
                if (issue_instr.r.opcode == op_reg)
                begin
                    ctrl.ex_ctrlwd.alumux2_sel = alumux2_rs2_out;
                end
                else
                begin
                    ctrl.ex_ctrlwd.cmpmux_sel = cmpmux_i_imm;
                end
                case (issue_instr.r.funct3)
                    3'b000: ctrl.ex_ctrlwd.aluop =
                        (alt && issue_instr.r.opcode == op_reg) ? alu_sub : alu_add;
                    3'b010:
                    begin
                        ctrl.wbmux_sel       = wbmux_br_en; // slt via the comparator.
                        ctrl.ex_ctrlwd.cmpop = blt;
                    end
                    3'b011:
                    begin
                        ctrl.wbmux_sel       = wbmux_br_en;
                        ctrl.ex_ctrlwd.cmpop = bltu;
                    end
                    3'b101: ctrl.ex_ctrlwd.aluop = alt ? alu_sra : alu_srl;
                    default: ;
                endcase
            end
            default: ctrl = '0; // unknown opcode.
        endcase
        if (!issue_valid)
        begin
            ctrl = '0;
        end
    end

    // immediates.
    always_comb
    begin
        id_next         = '0;
        id_next.ctrl_wd = ctrl;
        id_next.rs1_out = rs1_data;
        id_next.rs2_out = rs2_data;
        id_next.rd      = issue_instr.r.rd;
        id_next.i_imm   = {{20{issue_instr.i.imm[11]}}, issue_instr.i.imm};
        id_next.s_imm   = {{20{issue_instr.s.imm_hi[6]}}, issue_instr.s.imm_hi,
                           issue_instr.s.imm_lo};
        id_next.b_imm   = {{20{issue_instr.b.imm12}}, issue_instr.b.imm11,
                           issue_instr.b.imm10_5, issue_instr.b.imm4_1, 1'b0};
        id_next.u_imm   = {issue_instr.u.imm31_12, 12'h000};
        id_next.j_imm   = {{12{issue_instr.j.imm20}}, issue_instr.j.imm19_12,
                           issue_instr.j.imm11, issue_instr.j.imm10_1, 1'b0};
    end

    always_ff @(posedge clk)
    begin
        id_ex <= id_next;
        if (!rst_n)
        begin
            id_ex.ctrl_wd.valid        <= 1'b0;
            id_ex.ctrl_wd.load_regfile <= 1'b0;
        end
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/100ps
`include "rv32i_settings.svh"

module regfile
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  rv32i_types::rv32i_reg  rd,
    input  rv32i_types::rv32i_word wdata,
    input  rv32i_types::rv32i_reg  rs1_addr,
    input  rv32i_types::rv32i_reg  rs2_addr,
    output rv32i_types::rv32i_word rs1_data,
    output rv32i_types::rv32i_word rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [1:`RV_NREGS-1]; // no storage behind x0.

    // same-cycle write is forwarded to the reader.
    function automatic rv32i_word read_port(input rv32i_reg addr);
        if (addr == '0)
        begin
            return '0;
        end
        if (we && addr == rd)
        begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < `RV_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && rd != '0)
        begin
            regs[rd] <= wdata;
        end
    end

    always_comb
    begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

//--- hw/rv32i_types.sv
`include "rv32i_settings.svh"

package rv32i_types;

    typedef logic [`RV_XLEN-1:0]          rv32i_word;
    typedef logic [$clog2(`RV_NREGS)-1:0] rv32i_reg;

    // ########################################################################
    // encodings
    // ########################################################################
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // funct3 order with sra and sub in the slt slots.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;
    typedef enum logic [2:0] {
        alumux2_i_imm,
        alumux2_u_imm,
        alumux2_b_imm,
        alumux2_s_imm,
        alumux2_j_imm,
        alumux2_rs2_out
    } alumux2_sel_t;
    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;
    typedef enum logic {marmux_pc_out, marmux_alu_out} marmux_sel_t;
    typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2} pcmux_sel_t;
    typedef enum logic [1:0] {
        wbmux_alu_out,
        wbmux_br_en,
        wbmux_u_imm,
        wbmux_pc_plus4
    } wbmux_sel_t;

    // ########################################################################
    // instruction formats
    // ########################################################################
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            rv32i_reg   rs2;
            rv32i_reg   rs1;
            logic [2:0] funct3;
            rv32i_reg   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [7:0]  rs1_funct3;
            logic [11:0] rd_opcode;
        } i;
        struct packed {
            logic [6:0]  imm_hi;
            logic [12:0] regs_funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [12:0] regs_funct3;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [11:0] rd_opcode;
        } u;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [11:0] rd_opcode;
        } j;
    } rv32i_instr_u;

    // ########################################################################
    // stage registers
    // ########################################################################
    typedef struct packed {
        alu_ops       aluop;
        branch_funct3 cmpop;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmpmux_sel_t  cmpmux_sel;
        marmux_sel_t  marmux_sel;
        logic         is_branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic        valid;
        rv32i_opcode opcode;
        rv32i_word   pc;
        logic [2:0]  funct3;
        logic        load_regfile;
        wbmux_sel_t  wbmux_sel;
        ex_ctrl_t    ex_ctrlwd;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl_wd;
        rv32i_word  rs1_out;
        rv32i_word  rs2_out;
        rv32i_word  i_imm;
        rv32i_word  s_imm;
        rv32i_word  b_imm;
        rv32i_word  u_imm;
        rv32i_word  j_imm;
        rv32i_reg   rd;
    } ID_EX_stage_t;

    typedef struct packed {
        ctrl_word_t ctrl_wd;
        rv32i_word  alu_out;
        logic       cmp_out;
        rv32i_word  mar;
        rv32i_word  mem_data_out;
        rv32i_word  u_imm;
        rv32i_reg   rd;
        pcmux_sel_t pcmux_sel;
    } EX_MEM_stage_t;

endpackage

//--- hw/rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// datapath width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_NREGS 32

// default pc for issued code.
`define RV_RESET_PC 32'h0000_0060

`endif
